/* bench/bridge_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module bridge_asserts
(
	input wire clk,
	input wire rst,
	input wire arvalid,
	input wire arready,
	input wire [`ID_W+`ADDR_W+8:0] ar_fields, // arid araddr arlen arsize arburst
	input wire awvalid,
	input wire awready,
	input wire [`ADDR_W+8:0] aw_fields,
	input wire wvalid,
	input wire wready,
	input wire [`DATA_W+`DATA_W/8:0] w_fields, // wdata wstrb wlast
	input wire bvalid
);

	logic aw_open; // between aw and b handshakes

	always_ff @(posedge clk)
	begin
		if (!rst)
			aw_open <= 1'b0;
		else if (awvalid && awready)
			aw_open <= 1'b1;
		else if (bvalid)
			aw_open <= 1'b0;
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(ar_fields))
		else $error("ar channel changed before its handshake");

	aw_hold: assert property (@(posedge clk) disable iff (!rst)
		awvalid && !awready |=> awvalid && $stable(aw_fields))
		else $error("aw channel changed before its handshake");

	w_hold: assert property (@(posedge clk) disable iff (!rst)
		wvalid && !wready |=> wvalid && $stable(w_fields))
		else $error("w channel changed before its handshake");

	// reads stay parked behind a write in flight
	no_read_in_write: assert property (@(posedge clk) disable iff (!rst)
		aw_open |-> !$rose(arvalid))
		else $error("arvalid rose while a write was pending");

endmodule

bind axi_cache_bridge bridge_asserts u_asserts
(
	.clk (clk),
	.rst (rst),
	.arvalid (arvalid),
	.arready (arready),
	.ar_fields ({arid, araddr, arlen, arsize, arburst}),
	.awvalid (awvalid),
	.awready (awready),
	.aw_fields ({awaddr, awlen, awsize, awburst}),
	.wvalid (wvalid),
	.wready (wready),
	.w_fields ({wdata, wstrb, wlast}),
	.bvalid (bvalid)
);

`default_nettype wire

/* bench/tb_axi_cache_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module tb_axi_cache_bridge import bridge_pkg::*;
();

	localparam int NUM_ROWS = 8;
	localparam int PERIOD = 40;
	localparam int WATCHDOG_NS = NUM_ROWS * 20 * 8 * PERIOD;
	localparam logic [1:0] K_IC = 2'd0;
	localparam logic [1:0] K_DC = 2'd1;
	localparam logic [1:0] K_WR = 2'd2;
	localparam logic [1:0] K_BOTH = 2'd3; // icache and dcache in the same cycle

	typedef struct packed
	{
		logic [1:0] kind;
		logic conf;
		logic [`ADDR_W-1:0] addr;
		logic [2:0] size;
		logic [`DATA_W/8-1:0] strb;
		logic [31:0] seed;
	} row_t;

	typedef struct packed
	{
		logic [`ID_W-1:0] id;
		logic [`ADDR_W-1:0] addr;
		logic [3:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} addr_rec_t;

	typedef struct packed
	{
		logic [`DATA_W-1:0] data;
		logic [`DATA_W/8-1:0] strb;
		logic last;
	} beat_rec_t;

	logic clk;
	logic rst;
	logic conf_sel;
	logic ic_rd_req, ic_rd_rdy, ic_ret_valid, ic_ret_last;
	logic [2:0] ic_rd_type;
	logic [`ADDR_W-1:0] ic_rd_addr;
	logic [`DATA_W-1:0] ic_ret_data;
	logic dc_rd_req, dc_rd_rdy, dc_ret_valid, dc_ret_last;
	logic [2:0] dc_rd_type;
	logic [`ADDR_W-1:0] dc_rd_addr;
	logic [`DATA_W-1:0] dc_ret_data;
	logic dc_wr_req, dc_wr_rdy;
	logic [2:0] dc_wr_type;
	logic [`ADDR_W-1:0] dc_wr_addr;
	logic [`DATA_W/8-1:0] dc_wr_strb;
	line_word_u dc_wr_data;
	logic [`DATA_W-1:0] dc_uncache_wr_data;
	logic [`ID_W-1:0] arid, rid;
	logic [`ADDR_W-1:0] araddr, awaddr;
	logic [3:0] arlen, awlen;
	logic [2:0] arsize, awsize;
	logic [1:0] arburst, awburst;
	logic arvalid, arready, rlast, rvalid;
	logic [`DATA_W-1:0] rdata, wdata;
	logic awvalid, awready, wlast, wvalid, wready, bvalid;
	logic [`DATA_W/8-1:0] wstrb;

	row_t rows [NUM_ROWS];
	addr_rec_t ar_q [$];
	addr_rec_t aw_q [$];
	beat_rec_t ic_q [$];
	beat_rec_t dc_q [$];
	beat_rec_t w_q [$];
	time ar_t [$];
	time ic_last_t;
	bit ic_done;
	bit dc_done;
	bit wr_active; // write accepted, b not yet seen
	int b_cnt;
	int errors;
	integer seed = 32'h3763;

	// slave model state
	bit rd_busy;
	int rd_beat;
	addr_rec_t rd_rec;
	bit b_due;

	axi_cache_bridge uut (.*);

	function automatic logic [31:0] mem_word(input logic [31:0] addr, input int beat);
		return (addr + 32'(beat) * 4) ^ 32'ha5c3_0000; // slave memory contents
	endfunction

	function automatic logic [31:0] line_word(input logic [31:0] s, input int idx);
		return (s * 32'h9e37) ^ (32'(idx) * 32'h0101_0101);
	endfunction

	function automatic addr_rec_t expect_addr(input int id, input logic [31:0] addr,
		input logic [2:0] size, input logic single);
		addr_rec_t r;
		r.id = `ID_W'(id);
		r.addr = addr;
		r.len = single ? 4'd0 : 4'(`BURST_LEN_LINE);
		r.size = size;
		r.burst = single ? `BURST_FIXED : `BURST_INCR;
		return r;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic check_addr(input addr_rec_t got, input addr_rec_t exp, input string what);
		if (got !== exp)
			flag_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_ret(input bit is_ic, input logic [31:0] addr, input int n);
		beat_rec_t b;
		int cnt;
		cnt = is_ic ? ic_q.size() : dc_q.size();
		if (cnt != n)
			flag_error($sformatf("%s port got %0d beats, expected %0d",
				is_ic ? "icache" : "dcache", cnt, n));
		for (int i = 0; i < cnt && i < n; i++)
		begin
			b = is_ic ? ic_q[i] : dc_q[i];
			if (b.data !== mem_word(addr, i) || b.last !== (i == n - 1))
				flag_error($sformatf("return beat %0d data %h last %b", i, b.data, b.last));
		end
	endtask

	task automatic check_w(input row_t r);
		int n;
		logic [31:0] exp;
		n = r.conf ? 1 : `LINE_BEATS;
		if (w_q.size() != n)
			flag_error($sformatf("%0d w beats, expected %0d", w_q.size(), n));
		for (int i = 0; i < w_q.size() && i < n; i++)
		begin
			exp = r.conf ? (r.seed ^ 32'hc0de_0000) : line_word(r.seed, i);
			if (w_q[i].data !== exp || w_q[i].strb !== r.strb || w_q[i].last !== (i == n - 1))
				flag_error($sformatf("w beat %0d got %h expected %h", i, w_q[i], exp));
		end
	endtask

	task automatic raise_read(input bit is_ic, input logic [31:0] addr, input logic [2:0] size);
		if (is_ic)
		begin
			ic_rd_req = 1'b1;
			ic_rd_addr = addr;
			ic_rd_type = size;
		end
		else
		begin
			dc_rd_req = 1'b1;
			dc_rd_addr = addr;
			dc_rd_type = size;
		end
	endtask

	// hold the request until the edge that takes it
	task automatic await_accept(input bit is_ic);
		do
			@(negedge clk);
		while (!(is_ic ? ic_rd_rdy : dc_rd_rdy));
		@(posedge clk);
		#2;
		if (is_ic)
			ic_rd_req = 1'b0;
		else
			dc_rd_req = 1'b0;
	endtask

	task automatic wait_done(input bit is_ic);
		while (!(is_ic ? ic_done : dc_done))
			@(posedge clk);
	endtask

	task automatic run_row(input row_t r);
		ar_q.delete();
		aw_q.delete();
		ic_q.delete();
		dc_q.delete();
		w_q.delete();
		ar_t.delete();
		ic_done = 1'b0;
		dc_done = 1'b0;
		b_cnt = 0;
		@(posedge clk);
		#2;
		conf_sel = r.conf;
		case (r.kind)
			K_IC:
			begin
				raise_read(1'b1, r.addr, r.size);
				await_accept(1'b1);
				wait_done(1'b1);
				check_addr(ar_q[0], expect_addr(`ID_ICACHE, r.addr, r.size, 1'b0), "icache ar");
				check_ret(1'b1, r.addr, `LINE_BEATS);
				check_ret(1'b0, r.addr, 0);
			end
			K_DC:
			begin
				raise_read(1'b0, r.addr, r.size);
				await_accept(1'b0);
				wait_done(1'b0);
				check_addr(ar_q[0], expect_addr(`ID_DCACHE, r.addr, r.size, r.conf), "dcache ar");
				check_ret(1'b0, r.addr, r.conf ? 1 : `LINE_BEATS);
				check_ret(1'b1, r.addr, 0);
			end
			K_BOTH:
			begin
				raise_read(1'b1, r.addr, r.size);
				raise_read(1'b0, r.addr + 32'h100, r.size);
				await_accept(1'b1);
				await_accept(1'b0);
				wait_done(1'b0);
				check_addr(ar_q[0], expect_addr(`ID_ICACHE, r.addr, r.size, 1'b0), "first ar");
				check_addr(ar_q[1], expect_addr(`ID_DCACHE, r.addr + 32'h100, r.size, r.conf),
					"second ar");
				if (ar_t.size() < 2 || ar_t[1] <= ic_last_t)
					flag_error("dcache ar not after icache rlast");
				check_ret(1'b1, r.addr, `LINE_BEATS);
				check_ret(1'b0, r.addr + 32'h100, `LINE_BEATS);
			end
			default:
			begin
				dc_wr_req = 1'b1;
				dc_wr_addr = r.addr;
				dc_wr_type = r.size;
				dc_wr_strb = r.strb;
				for (int i = 0; i < `LINE_BEATS; i++)
					dc_wr_data.word[i] = line_word(r.seed, i);
				dc_uncache_wr_data = r.seed ^ 32'hc0de_0000;
				do
					@(negedge clk);
				while (!dc_wr_rdy);
				@(posedge clk);
				#2;
				dc_wr_req = 1'b0;
				wr_active = 1'b1;
				raise_read(1'b1, r.addr + 32'h400, r.size); // parked behind the write
				await_accept(1'b1);
				wait_done(1'b1);
				if (b_cnt != 1)
					flag_error($sformatf("%0d b handshakes, expected 1", b_cnt));
				check_addr(aw_q[0], expect_addr(0, r.addr, r.size, r.conf), "aw");
				check_w(r);
				check_addr(ar_q[0], expect_addr(`ID_ICACHE, r.addr + 32'h400, r.size, 1'b0),
					"ar after write");
				check_ret(1'b1, r.addr + 32'h400, `LINE_BEATS);
			end
		endcase
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// axi slave, samples at negedge and drives after the rising edge
	initial
	begin
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rid = '0;
		rdata = '0;
		bvalid = 1'b0;
		rd_busy = 1'b0;
		rd_beat = 0;
		rd_rec = '0;
		b_due = 1'b0;
		forever
		begin
			@(negedge clk);
			if (ic_ret_valid)
			begin
				ic_q.push_back(beat_rec_t'{ic_ret_data, 4'h0, ic_ret_last});
				if (ic_ret_last)
				begin
					ic_done = 1'b1;
					ic_last_t = $time;
				end
			end
			if (dc_ret_valid)
			begin
				dc_q.push_back(beat_rec_t'{dc_ret_data, 4'h0, dc_ret_last});
				if (dc_ret_last)
					dc_done = 1'b1;
			end
			if (rvalid)
			begin
				if (rlast)
					rd_busy = 1'b0;
				else
					rd_beat++;
			end
			if (arvalid && arready)
			begin
				rd_rec = addr_rec_t'{arid, araddr, arlen, arsize, arburst};
				ar_q.push_back(rd_rec);
				ar_t.push_back($time);
				rd_busy = 1'b1;
				rd_beat = 0;
			end
			if (awvalid && awready)
				aw_q.push_back(addr_rec_t'{`ID_W'(0), awaddr, awlen, awsize, awburst});
			if (wvalid && wready)
			begin
				w_q.push_back(beat_rec_t'{wdata, wstrb, wlast});
				if (wlast)
					b_due = 1'b1;
			end
			if (ic_rd_req && dc_rd_rdy)
				flag_error("dc_rd_rdy high while the icache was requesting");
			if (wr_active && arvalid)
				flag_error("arvalid seen while a write was in progress");
			if (wr_active && dc_wr_rdy)
				flag_error("dc_wr_rdy high while a write was in progress");
			if (bvalid)
			begin
				b_cnt++;
				wr_active = 1'b0;
			end
			@(posedge clk);
			#2;
			arready = ($random(seed) & 3) != 0; // stall about one cycle in four
			awready = ($random(seed) & 3) != 0;
			wready = ($random(seed) & 3) != 0;
			rvalid = rd_busy;
			rid = rd_rec.id;
			rdata = mem_word(rd_rec.addr, rd_beat);
			rlast = rd_busy && (rd_beat == int'(rd_rec.len));
			bvalid = b_due;
			b_due = 1'b0;
		end
	end

	initial
	begin
		rst = 1'b0;
		conf_sel = 1'b0;
		ic_rd_req = 1'b0;
		ic_rd_type = 3'd0;
		ic_rd_addr = '0;
		dc_rd_req = 1'b0;
		dc_rd_type = 3'd0;
		dc_rd_addr = '0;
		dc_wr_req = 1'b0;
		dc_wr_type = 3'd0;
		dc_wr_addr = '0;
		dc_wr_strb = '0;
		dc_wr_data = '0;
		dc_uncache_wr_data = '0;
		wr_active = 1'b0;
		errors = 0;
		// kind, conf_sel, address, size, strobe, data seed
		rows[0] = '{K_IC, 1'b0, 32'h0000_1000, 3'd2, 4'hf, 32'h0};
		rows[1] = '{K_DC, 1'b0, 32'h0000_2040, 3'd2, 4'hf, 32'h0};
		rows[2] = '{K_DC, 1'b1, 32'h1faf_0004, 3'd2, 4'hf, 32'h0};
		rows[3] = '{K_BOTH, 1'b0, 32'h0000_4000, 3'd2, 4'hf, 32'h0};
		rows[4] = '{K_WR, 1'b0, 32'h0000_3000, 3'd2, 4'hf, 32'h0000_1234};
		rows[5] = '{K_WR, 1'b1, 32'h1faf_0010, 3'd1, 4'h3, 32'h0000_5678};
		rows[6] = '{K_WR, 1'b0, 32'h0000_3400, 3'd2, 4'hf, 32'h0000_9abc};
		rows[7] = '{K_IC, 1'b0, 32'h0000_10c0, 3'd2, 4'hf, 32'h0};
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b1;
		@(negedge clk);
		if (arvalid || awvalid || wvalid || ic_ret_valid || dc_ret_valid || !ic_rd_rdy
			|| !dc_rd_rdy || !dc_wr_rdy)
			flag_error("outputs not at their reset values");
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(rows[i]);
		repeat (2) @(posedge clk);
		$display("rows %0d, errors %0d", NUM_ROWS, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog sized from the row count
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/bridge_pkg.sv
source/bridge_ifs.sv
source/request_arbiter.sv
source/read_engine.sv
source/write_engine.sv
source/axi_cache_bridge.sv
bench/bridge_asserts.sv
bench/tb_axi_cache_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axi_cache_bridge -f compile.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi

/* source/axi_cache_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module axi_cache_bridge
(
	input wire clk,
	input wire rst,
	input wire conf_sel, // uncached access select
	// icache
	input wire ic_rd_req,
	input wire [2:0] ic_rd_type,
	input wire [`ADDR_W-1:0] ic_rd_addr,
	output logic ic_rd_rdy,
	output logic ic_ret_valid,
	output logic ic_ret_last,
	output logic [`DATA_W-1:0] ic_ret_data,
	// dcache
	input wire dc_rd_req,
	input wire [2:0] dc_rd_type,
	input wire [`ADDR_W-1:0] dc_rd_addr,
	output logic dc_rd_rdy,
	output logic dc_ret_valid,
	output logic dc_ret_last,
	output logic [`DATA_W-1:0] dc_ret_data,
	input wire dc_wr_req,
	input wire [2:0] dc_wr_type,
	input wire [`ADDR_W-1:0] dc_wr_addr,
	input wire [`DATA_W/8-1:0] dc_wr_strb,
	input wire [`LINE_W-1:0] dc_wr_data,
	input wire [`DATA_W-1:0] dc_uncache_wr_data,
	output logic dc_wr_rdy,
	// axi read
	output logic [`ID_W-1:0] arid,
	output logic [`ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input wire arready,
	input wire [`ID_W-1:0] rid,
	input wire [`DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid,
	// axi write
	output logic [`ADDR_W-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic awvalid,
	input wire awready,
	output logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W/8-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire bvalid
);

	rd_req_if rd_bus ();
	wr_req_if wr_bus ();

	request_arbiter u_arb
	(
		.clk, .rst, .conf_sel,
		.ic_rd_req, .ic_rd_type, .ic_rd_addr,
		.dc_rd_req, .dc_rd_type, .dc_rd_addr,
		.dc_wr_req, .dc_wr_type, .dc_wr_addr, .dc_wr_strb,
		.dc_wr_data (dc_wr_data), // flat line into the union port
		.dc_uncache_wr_data,
		.ic_rd_rdy, .dc_rd_rdy, .dc_wr_rdy,
		.rd (rd_bus.master),
		.wr (wr_bus.master)
	);

	read_engine u_rd
	(
		.clk, .rst,
		.rd (rd_bus.slave),
		.arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rid, .rdata, .rlast, .rvalid,
		.ic_ret_valid, .ic_ret_last, .ic_ret_data,
		.dc_ret_valid, .dc_ret_last, .dc_ret_data
	);

	write_engine u_wr
	(
		.clk, .rst,
		.wr (wr_bus.slave),
		.awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wdata, .wstrb, .wlast, .wvalid, .wready,
		.bvalid
	);

endmodule

`default_nettype wire

/* source/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define ID_W 4

// cache line geometry
`define LINE_BEATS 16
`define LINE_W 512

// arlen / awlen for a full line, 16 beats
`define BURST_LEN_LINE 15

// axi burst types
`define BURST_INCR 2'b01
`define BURST_FIXED 2'b00

// read ids, low bit picks the returning cache
`define ID_ICACHE 0
`define ID_DCACHE 1

`endif

/* source/bridge_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

// read request from arbiter to read engine
interface rd_req_if import bridge_pkg::*; ();
	logic valid; // one cycle pulse
	rd_src_e src;
	logic [`ADDR_W-1:0] addr;
	logic [2:0] size;
	logic single; // uncached, one fixed beat
	logic idle; // no read outstanding

	modport master (output valid, src, addr, size, single, input idle);
	modport slave (input valid, src, addr, size, single, output idle);
endinterface

// write request from arbiter to write engine
interface wr_req_if import bridge_pkg::*; ();
	logic valid; // one cycle pulse
	logic [`ADDR_W-1:0] addr;
	logic [2:0] size;
	logic [`DATA_W/8-1:0] strb;
	logic single;
	line_word_u line;
	logic [`DATA_W-1:0] word; // uncached word
	logic done; // pulses on b handshake

	modport master
	(
		output valid, addr, size, strb, single, line, word,
		input done
	);
	modport slave
	(
		input valid, addr, size, strb, single, line, word,
		output done
	);
endinterface

`default_nettype wire

/* source/bridge_pkg.sv */
`default_nettype none

`include "bridge_defs.svh"

package bridge_pkg;

	// writeback line, flat or per beat
	// word[0] sits in the low bits and goes out first
	typedef union packed
	{
		logic [`LINE_W-1:0] flat;
		logic [`LINE_BEATS-1:0][`DATA_W-1:0] word;
	} line_word_u;

	// who asked for the read
	typedef enum logic
	{
		SRC_INST = 1'b0,
		SRC_DATA = 1'b1
	} rd_src_e;

endpackage

`default_nettype wire

/* source/read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module read_engine import bridge_pkg::*;
(
	input wire clk,
	input wire rst,
	rd_req_if.slave rd,
	output logic [`ID_W-1:0] arid,
	output logic [`ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input wire arready,
	input wire [`ID_W-1:0] rid,
	input wire [`DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid,
	output logic ic_ret_valid,
	output logic ic_ret_last,
	output logic [`DATA_W-1:0] ic_ret_data,
	output logic dc_ret_valid,
	output logic dc_ret_last,
	output logic [`DATA_W-1:0] dc_ret_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;

	logic [1:0] state;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE: if (rd.valid) state <= ST_ADDR;
				ST_ADDR: if (arready) state <= ST_DATA; // arvalid is high here
				ST_DATA: if (rvalid && rlast) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ar fields held from the accepted request until the next one
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && rd.valid)
		begin
			arid <= (rd.src == SRC_INST) ? `ID_W'(`ID_ICACHE) : `ID_W'(`ID_DCACHE);
			araddr <= rd.addr;
			arsize <= rd.size;
			arlen <= rd.single ? 4'd0 : 4'(`BURST_LEN_LINE);
			arburst <= rd.single ? `BURST_FIXED : `BURST_INCR;
		end
	end

	assign arvalid = (state == ST_ADDR);
	assign rd.idle = (state == ST_IDLE);

	// beats routed by low id bit
	assign ic_ret_valid = (state == ST_DATA) && rvalid && !rid[0];
	assign dc_ret_valid = (state == ST_DATA) && rvalid && rid[0];
	assign ic_ret_last = ic_ret_valid && rlast;
	assign dc_ret_last = dc_ret_valid && rlast;
	assign ic_ret_data = rdata;
	assign dc_ret_data = rdata;

endmodule

`default_nettype wire

/* source/request_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module request_arbiter import bridge_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire conf_sel,
	input wire ic_rd_req,
	input wire [2:0] ic_rd_type,
	input wire [`ADDR_W-1:0] ic_rd_addr,
	input wire dc_rd_req,
	input wire [2:0] dc_rd_type,
	input wire [`ADDR_W-1:0] dc_rd_addr,
	input wire dc_wr_req,
	input wire [2:0] dc_wr_type,
	input wire [`ADDR_W-1:0] dc_wr_addr,
	input wire [`DATA_W/8-1:0] dc_wr_strb,
	input wire line_word_u dc_wr_data,
	input wire [`DATA_W-1:0] dc_uncache_wr_data,
	output logic ic_rd_rdy,
	output logic dc_rd_rdy,
	output logic dc_wr_rdy,
	rd_req_if.master rd,
	wr_req_if.master wr
);

	logic wr_pend; // write in flight, blocks reads and writes
	logic rd_ok;
	logic ic_take;
	logic dc_take;
	logic wr_take;

	// valid still high means the engine has not dropped idle yet
	assign rd_ok = rd.idle && !rd.valid && !wr_pend;
	assign ic_rd_rdy = rd_ok;
	assign dc_rd_rdy = rd_ok && !ic_rd_req; // icache wins
	assign dc_wr_rdy = !wr_pend;

	assign ic_take = ic_rd_req && ic_rd_rdy;
	assign dc_take = dc_rd_req && dc_rd_rdy;
	assign wr_take = dc_wr_req && dc_wr_rdy;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			rd.valid <= 1'b0;
			wr.valid <= 1'b0;
			wr_pend <= 1'b0;
		end
		else
		begin
			rd.valid <= ic_take || dc_take;
			wr.valid <= wr_take;
			if (wr_take)
				wr_pend <= 1'b1;
			else if (wr.done)
				wr_pend <= 1'b0; // b handshake seen
		end
	end

	// winning read request
	always_ff @(posedge clk)
	begin
		if (ic_take)
		begin
			rd.src <= SRC_INST;
			rd.addr <= ic_rd_addr;
			rd.size <= ic_rd_type;
			rd.single <= 1'b0; // instruction fetch always a line
		end
		else if (dc_take)
		begin
			rd.src <= SRC_DATA;
			rd.addr <= dc_rd_addr;
			rd.size <= dc_rd_type;
			rd.single <= conf_sel;
		end
	end

	// write capture, line and uncached word together
	always_ff @(posedge clk)
	begin
		if (wr_take)
		begin
			wr.addr <= dc_wr_addr;
			wr.size <= dc_wr_type;
			wr.strb <= dc_wr_strb;
			wr.single <= conf_sel;
			wr.line <= dc_wr_data;
			wr.word <= dc_uncache_wr_data;
		end
	end

endmodule

`default_nettype wire

/* source/write_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module write_engine import bridge_pkg::*;
(
	input wire clk,
	input wire rst,
	wr_req_if.slave wr,
	output logic [`ADDR_W-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic awvalid,
	input wire awready,
	output logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W/8-1:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire bvalid
);

	localparam int IDX_W = $clog2(`LINE_BEATS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`LINE_BEATS - 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;
	logic [IDX_W-1:0] beat_idx; // next word to send
	logic single_q;
	line_word_u line_buf;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= ST_IDLE;
			beat_idx <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					beat_idx <= '0;
					if (wr.valid)
						state <= ST_ADDR;
				end
				ST_ADDR:
					if (awready)
						state <= ST_DATA;
				ST_DATA:
				begin
					if (wready)
					begin
						if (wlast)
							state <= ST_RESP;
						else
							beat_idx <= beat_idx + 1'b1;
					end
				end
				ST_RESP:
					if (bvalid)
						state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// capture request, uncached word goes into beat 0
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && wr.valid)
		begin
			awaddr <= wr.addr;
			awsize <= wr.size;
			awlen <= wr.single ? 4'd0 : 4'(`BURST_LEN_LINE);
			awburst <= wr.single ? `BURST_FIXED : `BURST_INCR;
			wstrb <= wr.strb;
			single_q <= wr.single;
			line_buf.flat <= wr.line.flat;
			if (wr.single)
				line_buf.word[0] <= wr.word;
		end
	end

	assign awvalid = (state == ST_ADDR);
	assign wvalid = (state == ST_DATA);
	assign wdata = line_buf.word[beat_idx];
	assign wlast = single_q || (beat_idx == LAST_IDX);

	// bready is tied high on the bus side
	assign wr.done = (state == ST_RESP) && bvalid;

endmodule

`default_nettype wire
